// ==== files.f ====
logic/pagerank_pkg.sv
logic/vertex_job_fifo.sv
logic/edge_counter.sv
logic/vertex_control_fsm.sv
logic/read_port.sv
logic/rank_accumulator.sv
logic/pagerank_vertex_cu.sv
bench/tb_clock.sv
bench/tb_graph_memory.sv
bench/tb_pagerank.sv

// ==== Makefile ====
# Verilator build for the PageRank vertex compute unit

VERILATOR  ?= verilator
TOP        ?= tb_pagerank
RTL_TOP    ?= pagerank_vertex_cu
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall -Wno-fatal
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  := SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

lint-rtl:
	$(VERILATOR) --lint-only $(LINT_FLAGS) \
		logic/pagerank_pkg.sv logic/vertex_job_fifo.sv logic/edge_counter.sv \
		logic/vertex_control_fsm.sv logic/read_port.sv logic/rank_accumulator.sv \
		logic/pagerank_vertex_cu.sv --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_pagerank.sv ====
/*
 * PageRank vertex compute unit testbench
 * Random vertex jobs, reference sums from the graph formulas, handshake checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_pagerank;

	localparam int NUM_RANDOM_JOBS = 40;
	localparam int NUM_JOBS        = NUM_RANDOM_JOBS + 1;
	localparam int MAX_DEGREE      = 8;
	localparam int CYCLES_PER_READ = 12;
	localparam int CYCLE_LIMIT     =
		NUM_RANDOM_JOBS * (2 * MAX_DEGREE * CYCLES_PER_READ + 20) + 4000;
	localparam int DONE_WAIT       = 8;
	localparam int FIFO_DEPTH      = pagerank_pkg::JOB_FIFO_DEPTH;
	localparam logic [31:0] SEED   = 32'h24e555a5;
	localparam logic [pagerank_pkg::ADDR_W-1:0] LARGE_EDGE_BASE = 20'h80000;

	logic                                clock;
	logic                                rstn;
	logic                                job_req;
	logic [pagerank_pkg::VERTEX_W-1:0]   job_vertex;
	logic [pagerank_pkg::EDGE_W-1:0]     job_edge_base;
	logic [pagerank_pkg::DEGREE_W-1:0]   job_degree;
	logic                                job_ack;
	logic                                rd_req;
	logic [pagerank_pkg::ADDR_W-1:0]     rd_addr;
	pagerank_pkg::read_kind_t            rd_kind;
	logic                                rd_ack;
	logic [pagerank_pkg::RANK_W-1:0]     rd_data;
	logic                                wr_req;
	logic [pagerank_pkg::VERTEX_W-1:0]   wr_vertex;
	logic [pagerank_pkg::RANK_W-1:0]     wr_sum;
	logic                                wr_ack;
	logic                                wr_hold;
	logic [pagerank_pkg::VERTEX_W-1:0]   vertex_num_counter;
	logic [pagerank_pkg::EDGE_W-1:0]     edge_num_counter;

	// Job table and expected results in job order
	logic [pagerank_pkg::VERTEX_W-1:0] job_v [NUM_JOBS];
	logic [pagerank_pkg::EDGE_W-1:0]   job_b [NUM_JOBS];
	logic [pagerank_pkg::DEGREE_W-1:0] job_d [NUM_JOBS];
	logic [pagerank_pkg::VERTEX_W-1:0] exp_vertex [$];
	logic [pagerank_pkg::RANK_W-1:0]   exp_sum [$];
	int                                exp_degree [$];

	int errors            = 0;
	int read_errors       = 0;
	int tests_run         = 0;
	int tests_failed      = 0;
	int acks_seen         = 0;
	int writes_seen       = 0;
	int reads_since_write = 0;
	int total_degree      = 0;
	int cycles            = 0;
	logic job_ack_q;
	logic rd_req_q;
	logic wr_req_q;
	pagerank_pkg::read_kind_t last_kind;

	tb_clock i_clock (
		.clock(clock),
		.rstn (rstn)
	);

	pagerank_vertex_cu i_pagerank_vertex_cu (
		.clock             (clock),
		.rstn              (rstn),
		.job_req           (job_req),
		.job_vertex        (job_vertex),
		.job_edge_base     (job_edge_base),
		.job_degree        (job_degree),
		.job_ack           (job_ack),
		.rd_req            (rd_req),
		.rd_addr           (rd_addr),
		.rd_kind           (rd_kind),
		.rd_ack            (rd_ack),
		.rd_data           (rd_data),
		.wr_req            (wr_req),
		.wr_vertex         (wr_vertex),
		.wr_sum            (wr_sum),
		.wr_ack            (wr_ack),
		.vertex_num_counter(vertex_num_counter),
		.edge_num_counter  (edge_num_counter)
	);

	tb_graph_memory #(
		.SEED           (SEED),
		.LARGE_EDGE_BASE(LARGE_EDGE_BASE)
	) i_graph_memory (
		.clock  (clock),
		.rstn   (rstn),
		.rd_req (rd_req),
		.rd_addr(rd_addr),
		.rd_kind(rd_kind),
		.rd_ack (rd_ack),
		.rd_data(rd_data),
		.wr_req (wr_req),
		.wr_ack (wr_ack),
		.wr_hold(wr_hold)
	);

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	function automatic logic [31:0] lcg_next(input logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [15:0] neighbour_of(input logic [19:0] a);
		logic [15:0] n;
		n = 16'((32'(a) * 7 + 3) % 1024);
		if (a >= LARGE_EDGE_BASE)
			n = n | 16'h8000;
		return n;
	endfunction

	function automatic logic [31:0] rank_of(input logic [15:0] v);
		return 32'(v) * 32'd4096 + 32'd1;
	endfunction

	// Rank sum clamped at all ones
	function automatic logic [31:0] expected_sum(input logic [19:0] base, input int degree);
		logic [32:0] acc;
		int i;
		acc = '0;
		for (i = 0; i < degree; i++) begin
			acc = acc + {1'b0, rank_of(neighbour_of(base + 20'(i)))};
			if (acc[32])
				acc = 33'h0_ffff_ffff;
		end
		return acc[31:0];
	endfunction

	// Address of read n of job j, edge and rank reads take turns
	function automatic logic [19:0] read_address(input int j, input int n);
		logic [19:0] addr;
		addr = job_b[j] + 20'(n / 2);
		if (n % 2 != 0)
			addr = {4'h0, neighbour_of(addr)};
		return addr;
	endfunction

	task automatic build_jobs();
		logic [31:0] seed;
		int i;
		seed = SEED;
		for (i = 0; i < NUM_RANDOM_JOBS; i++) begin
			seed     = lcg_next(seed);
			job_v[i] = 16'(i * 5 + 2);
			job_b[i] = {1'b0, seed[30:12]};
			job_d[i] = (i == 3) ? 8'd0 : {5'b0, seed[10:8]};
		end
		// Long vertex whose ranks overflow the sum
		job_v[NUM_RANDOM_JOBS] = 16'hbeef;
		job_b[NUM_RANDOM_JOBS] = LARGE_EDGE_BASE;
		job_d[NUM_RANDOM_JOBS] = 8'd255;
		for (i = 0; i < NUM_JOBS; i++) begin
			exp_vertex.push_back(job_v[i]);
			exp_sum.push_back(expected_sum(job_b[i], int'(job_d[i])));
			exp_degree.push_back(int'(job_d[i]));
			total_degree += int'(job_d[i]);
		end
	endtask

	////////////////////////////////////////
	// Checks and reporting
	////////////////////////////////////////
	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic protocol_error(input string what);
		$display("Handshake violation: %s at cycle %0d", what, cycles);
		errors++;
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (errors != err_before) begin
			tests_failed++;
			$display("Test %s: failed", name);
		end else begin
			$display("Test %s: ok", name);
		end
	endtask

	// Read errors count toward the job that issued the read
	task automatic check_read_address();
		int err_before;
		err_before = errors;
		check_value($sformatf("job %0d read %0d address", writes_seen, reads_since_write),
			32'(read_address(writes_seen, reads_since_write)), 32'(rd_addr));
		read_errors += errors - err_before;
	endtask

	task automatic check_write();
		int err_before;
		string name;
		err_before  = errors - read_errors;
		read_errors = 0;
		name = $sformatf("job %0d", writes_seen);
		if (exp_vertex.size() == 0) begin
			$display("Write of vertex %0h arrived with no job pending", wr_vertex);
			errors++;
		end else begin
			check_value({name, " vertex"}, 32'(exp_vertex.pop_front()), 32'(wr_vertex));
			check_value({name, " sum"}, exp_sum.pop_front(), wr_sum);
			check_value({name, " reads"}, 32'(2 * exp_degree.pop_front()),
				32'(reads_since_write));
		end
		end_test(name, err_before);
	endtask

	// Edge detection, read kind history and write checks
	always @(posedge clock) begin
		if (!rstn) begin
			job_ack_q         <= 1'b0;
			rd_req_q          <= 1'b0;
			wr_req_q          <= 1'b0;
			last_kind         <= pagerank_pkg::READ_RANK;
			reads_since_write <= 0;
		end else begin
			job_ack_q <= job_ack;
			rd_req_q  <= rd_req;
			wr_req_q  <= wr_req;
			if (job_ack && !job_ack_q)
				acks_seen <= acks_seen + 1;
			if (rd_req && !rd_req_q) begin
				if (writes_seen < NUM_JOBS)
					check_read_address();
				last_kind         <= rd_kind;
				reads_since_write <= reads_since_write + 1;
			end
			if (wr_req && !wr_req_q) begin
				check_write();
				reads_since_write <= 0;
				writes_seen       <= writes_seen + 1;
			end
		end
	end

	////////////////////////////////////////
	// Handshake assertions
	////////////////////////////////////////
	assert property (@(posedge clock) disable iff (!rstn) $rose(job_ack) |-> job_req)
		else protocol_error("job_ack rose without job_req");
	assert property (@(posedge clock) disable iff (!rstn) $fell(job_ack) |-> !job_req)
		else protocol_error("job_ack fell while job_req was high");
	assert property (@(posedge clock) disable iff (!rstn) $fell(job_req) |-> job_ack)
		else protocol_error("job_req fell before job_ack rose");
	assert property (@(posedge clock) disable iff (!rstn) $rose(job_req) |-> !job_ack)
		else protocol_error("job_req rose while job_ack was high");
	assert property (@(posedge clock) disable iff (!rstn) $fell(rd_req) |-> rd_ack)
		else protocol_error("rd_req fell before rd_ack rose");
	assert property (@(posedge clock) disable iff (!rstn) $rose(rd_req) |-> !rd_ack)
		else protocol_error("rd_req rose while rd_ack was high");
	assert property (@(posedge clock) disable iff (!rstn) $rose(rd_req) |-> rd_kind != last_kind)
		else protocol_error("two reads of the same kind in a row");
	assert property (@(posedge clock) disable iff (!rstn) $fell(wr_req) |-> wr_ack)
		else protocol_error("wr_req fell before wr_ack rose");
	assert property (@(posedge clock) disable iff (!rstn) $rose(wr_req) |-> !wr_ack)
		else protocol_error("wr_req rose while wr_ack was high");
	assert property (@(posedge clock) disable iff (!rstn)
		(acks_seen - writes_seen) < FIFO_DEPTH + 2)
		else protocol_error("too many jobs accepted ahead of the last write");

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	task automatic send_jobs();
		int i;
		for (i = 0; i < NUM_JOBS; i++) begin
			job_req       <= 1'b1;
			job_vertex    <= job_v[i];
			job_edge_base <= job_b[i];
			job_degree    <= job_d[i];
			do @(posedge clock); while (!job_ack);
			job_req <= 1'b0;
			do @(posedge clock); while (job_ack);
		end
	endtask

	// Stall the sink until the FIFO is full, then let it drain
	task automatic hold_writes();
		int err_before;
		while (acks_seen < FIFO_DEPTH + 1)
			@(posedge clock);
		repeat (20) @(posedge clock);
		err_before = errors;
		check_value("backpressure accepted jobs", 32'(FIFO_DEPTH + 1), 32'(acks_seen));
		check_value("backpressure writes", 32'd1, 32'(writes_seen));
		wr_hold <= 1'b0;
		end_test("backpressure", err_before);
	endtask

	initial begin : main
		int err_before;
		int settle;
		job_req       = 1'b0;
		job_vertex    = '0;
		job_edge_base = '0;
		job_degree    = '0;
		wr_hold       = 1'b1;
		build_jobs();
		@(posedge rstn);
		@(posedge clock);
		err_before = errors;
		check_value("reset job_ack", 32'd0, 32'(job_ack));
		check_value("reset rd_req", 32'd0, 32'(rd_req));
		check_value("reset wr_req", 32'd0, 32'(wr_req));
		check_value("reset vertex count", 32'd0, 32'(vertex_num_counter));
		check_value("reset edge count", 32'd0, 32'(edge_num_counter));
		end_test("reset", err_before);
		fork
			send_jobs();
			hold_writes();
		join
		while (writes_seen < NUM_JOBS || wr_req || wr_ack)
			@(posedge clock);
		// Last vertex is counted once the FSM leaves its write state
		settle = 0;
		while (vertex_num_counter != NUM_JOBS && settle < DONE_WAIT) begin
			@(posedge clock);
			settle++;
		end
		err_before = errors;
		check_value("vertex count", 32'(NUM_JOBS), 32'(vertex_num_counter));
		check_value("edge count", 32'(total_degree % (1 << pagerank_pkg::EDGE_W)),
			32'(edge_num_counter));
		end_test("counters", err_before);
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Run limit from the job count and read cost
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, %0d of %0d writes seen",
				cycles, writes_seen, NUM_JOBS);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== bench/tb_graph_memory.sv ====
/*
 * Graph memory and write sink model
 * Edge and rank words from fixed formulas, acks after random delays
 */
`timescale 1ns/1ps
`default_nettype none

module tb_graph_memory #(
	parameter logic [31:0]                     SEED            = 32'h1,
	parameter logic [pagerank_pkg::ADDR_W-1:0] LARGE_EDGE_BASE = '1
) (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic                              rd_req,
	input  logic [pagerank_pkg::ADDR_W-1:0]   rd_addr,
	input  logic                              rd_kind,
	output logic                              rd_ack,
	output logic [pagerank_pkg::RANK_W-1:0]   rd_data,
	input  logic                              wr_req,
	output logic                              wr_ack,
	input  logic                              wr_hold
);

	logic [31:0] seed      = SEED;
	logic        rd_ack_q  = 1'b0;
	logic [31:0] rd_data_q = '0;
	logic        wr_ack_q  = 1'b0;
	logic [1:0]  rd_wait   = '0;
	logic [1:0]  wr_wait   = '0;

	function automatic logic [31:0] lcg_next(input logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	// Edges in the upper region point into the upper vertex half
	function automatic logic [15:0] neighbour_of(input logic [19:0] a);
		logic [15:0] n;
		n = 16'((32'(a) * 7 + 3) % 1024);
		if (a >= LARGE_EDGE_BASE)
			n = n | 16'h8000;
		return n;
	endfunction

	function automatic logic [31:0] rank_of(input logic [15:0] v);
		return 32'(v) * 32'd4096 + 32'd1;
	endfunction

	always @(posedge clock)
		seed <= lcg_next(seed);

	////////////////////////////////////////
	// Read responder
	////////////////////////////////////////
	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_ack_q <= 1'b0;
			rd_wait  <= '0;
		end else if (rd_wait != 0) begin
			rd_wait <= rd_wait - 1'b1;
		end else if (rd_req && !rd_ack_q) begin
			rd_ack_q <= 1'b1;
			rd_wait  <= seed[17:16];
			if (rd_kind == pagerank_pkg::READ_RANK)
				rd_data_q <= rank_of(rd_addr[15:0]);
			else
				rd_data_q <= {16'h0000, neighbour_of(rd_addr)};
		end else if (!rd_req && rd_ack_q) begin
			rd_ack_q <= 1'b0;
			rd_wait  <= seed[19:18];
		end
	end

	// Write sink, held off while wr_hold is high
	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ack_q <= 1'b0;
			wr_wait  <= '0;
		end else if (wr_wait != 0) begin
			wr_wait <= wr_wait - 1'b1;
		end else if (wr_req && !wr_ack_q && !wr_hold) begin
			wr_ack_q <= 1'b1;
			wr_wait  <= seed[21:20];
		end else if (!wr_req && wr_ack_q) begin
			wr_ack_q <= 1'b0;
			wr_wait  <= seed[23:22];
		end
	end

	assign rd_ack  = rd_ack_q;
	assign rd_data = rd_data_q;
	assign wr_ack  = wr_ack_q;

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
/*
 * Testbench clock and reset
 * 4 ns clock, active low reset held for two cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		rstn = 1'b0;
		repeat (2) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== logic/pagerank_vertex_cu.sv ====
/*
 * PageRank vertex compute unit top level
 * Job FIFO, control FSM, edge counter, read port and rank accumulator
 */
`timescale 1ns/1ps
`default_nettype none

module pagerank_vertex_cu (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                job_req,
	input  logic [pagerank_pkg::VERTEX_W-1:0]   job_vertex,
	input  logic [pagerank_pkg::EDGE_W-1:0]     job_edge_base,
	input  logic [pagerank_pkg::DEGREE_W-1:0]   job_degree,
	output logic                                job_ack,
	output logic                                rd_req,
	output logic [pagerank_pkg::ADDR_W-1:0]     rd_addr,
	output pagerank_pkg::read_kind_t            rd_kind,
	input  logic                                rd_ack,
	input  logic [pagerank_pkg::RANK_W-1:0]     rd_data,
	output logic                                wr_req,
	output logic [pagerank_pkg::VERTEX_W-1:0]   wr_vertex,
	output logic [pagerank_pkg::RANK_W-1:0]     wr_sum,
	input  logic                                wr_ack,
	output logic [pagerank_pkg::VERTEX_W-1:0]   vertex_num_counter,
	output logic [pagerank_pkg::EDGE_W-1:0]     edge_num_counter
);

	// FIFO head
	logic                              fifo_valid;
	logic                              fsm_pop;
	logic [pagerank_pkg::VERTEX_W-1:0] head_vertex;
	logic [pagerank_pkg::EDGE_W-1:0]   head_edge_base;
	logic [pagerank_pkg::DEGREE_W-1:0] head_degree;

	// Edge counter
	logic                              vertex_load;
	logic                              edge_step;
	logic                              vertex_done;
	logic                              last_edge;
	logic [pagerank_pkg::DEGREE_W-1:0] edge_index;

	// Read command and result
	logic                              rd_start;
	logic [pagerank_pkg::ADDR_W-1:0]   rd_addr_next;
	pagerank_pkg::read_kind_t          rd_kind_next;
	logic                              rd_done;
	pagerank_pkg::read_word_t          rd_word;

	// Accumulator control
	logic acc_clear;
	logic acc_add;
	logic write_start;
	logic write_done;

	// Controller state for waveform debug
	pagerank_pkg::vertex_state_t fsm_state;

	////////////////////////////////////////
	// Vertex jobs
	////////////////////////////////////////
	vertex_job_fifo i_vertex_job_fifo (
		.clock         (clock),
		.rstn          (rstn),
		.job_req       (job_req),
		.job_vertex    (job_vertex),
		.job_edge_base (job_edge_base),
		.job_degree    (job_degree),
		.job_ack       (job_ack),
		.fsm_pop       (fsm_pop),
		.fifo_valid    (fifo_valid),
		.head_vertex   (head_vertex),
		.head_edge_base(head_edge_base),
		.head_degree   (head_degree)
	);

	edge_counter i_edge_counter (
		.clock             (clock),
		.rstn              (rstn),
		.vertex_load       (vertex_load),
		.edge_step         (edge_step),
		.vertex_done       (vertex_done),
		.degree            (head_degree),
		.last_edge         (last_edge),
		.edge_index        (edge_index),
		.vertex_num_counter(vertex_num_counter),
		.edge_num_counter  (edge_num_counter)
	);

	////////////////////////////////////////
	// Control
	////////////////////////////////////////
	vertex_control_fsm i_vertex_control_fsm (
		.clock         (clock),
		.rstn          (rstn),
		.fifo_valid    (fifo_valid),
		.head_edge_base(head_edge_base),
		.fsm_pop       (fsm_pop),
		.vertex_load   (vertex_load),
		.edge_step     (edge_step),
		.vertex_done   (vertex_done),
		.rd_start      (rd_start),
		.acc_clear     (acc_clear),
		.acc_add       (acc_add),
		.write_start   (write_start),
		.rd_addr_next  (rd_addr_next),
		.rd_kind_next  (rd_kind_next),
		.rd_done       (rd_done),
		.last_edge     (last_edge),
		.write_done    (write_done),
		.rd_word       (rd_word),
		.edge_index    (edge_index),
		.state         (fsm_state)
	);

	////////////////////////////////////////
	// Memory side
	////////////////////////////////////////
	read_port i_read_port (
		.clock       (clock),
		.rstn        (rstn),
		.rd_start    (rd_start),
		.rd_addr_next(rd_addr_next),
		.rd_kind_next(rd_kind_next),
		.rd_req      (rd_req),
		.rd_addr     (rd_addr),
		.rd_kind     (rd_kind),
		.rd_ack      (rd_ack),
		.rd_data     (rd_data),
		.rd_done     (rd_done),
		.rd_word     (rd_word)
	);

	rank_accumulator i_rank_accumulator (
		.clock      (clock),
		.rstn       (rstn),
		.acc_clear  (acc_clear),
		.acc_add    (acc_add),
		.write_start(write_start),
		.vertex_in  (head_vertex),
		.rank_in    (rd_word),
		.wr_req     (wr_req),
		.wr_vertex  (wr_vertex),
		.wr_sum     (wr_sum),
		.wr_ack     (wr_ack),
		.write_done (write_done)
	);

endmodule

`default_nettype wire

// ==== logic/rank_accumulator.sv ====
/*
 * Rank accumulator
 * Saturating sum of neighbour ranks and four-phase write-back of the result
 */
`timescale 1ns/1ps
`default_nettype none

module rank_accumulator (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                acc_clear,
	input  logic                                acc_add,
	input  logic                                write_start,
	input  logic [pagerank_pkg::VERTEX_W-1:0]   vertex_in,
	input  pagerank_pkg::read_word_t            rank_in,
	output logic                                wr_req,
	output logic [pagerank_pkg::VERTEX_W-1:0]   wr_vertex,
	output logic [pagerank_pkg::RANK_W-1:0]     wr_sum,
	input  logic                                wr_ack,
	output logic                                write_done
);

	logic [pagerank_pkg::RANK_W-1:0]   sum_q;
	logic [pagerank_pkg::RANK_W:0]     sum_wide;
	logic [pagerank_pkg::VERTEX_W-1:0] vertex_q;
	logic busy;

	////////////////////////////////////////
	// Sum kernel
	////////////////////////////////////////
	assign sum_wide = {1'b0, sum_q} + {1'b0, rank_in.rank};

	always_ff @(posedge clock) begin
		if (acc_clear) begin
			sum_q    <= '0;
			vertex_q <= vertex_in;
		end else if (acc_add) begin
			// Clamp to all ones on carry out
			sum_q <= sum_wide[pagerank_pkg::RANK_W] ? '1 : sum_wide[pagerank_pkg::RANK_W-1:0];
		end
	end

	assign wr_vertex = vertex_q;
	assign wr_sum    = sum_q;

	////////////////////////////////////////
	// Write-back handshake
	////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy       <= 1'b0;
			wr_req     <= 1'b0;
			write_done <= 1'b0;
		end else begin
			write_done <= 1'b0;
			if (!busy) begin
				if (write_start) begin
					busy   <= 1'b1;
					wr_req <= 1'b1;
				end
			end else if (wr_req) begin
				if (wr_ack)
					wr_req <= 1'b0;
			end else if (!wr_ack) begin
				busy       <= 1'b0;
				write_done <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/read_port.sv ====
/*
 * Read port
 * Four-phase read master, one read at a time, word decoded by read kind
 */
`timescale 1ns/1ps
`default_nettype none

module read_port (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                rd_start,
	input  logic [pagerank_pkg::ADDR_W-1:0]     rd_addr_next,
	input  pagerank_pkg::read_kind_t            rd_kind_next,
	output logic                                rd_req,
	output logic [pagerank_pkg::ADDR_W-1:0]     rd_addr,
	output pagerank_pkg::read_kind_t            rd_kind,
	input  logic                                rd_ack,
	input  logic [pagerank_pkg::RANK_W-1:0]     rd_data,
	output logic                                rd_done,
	output pagerank_pkg::read_word_t            rd_word
);

	// High from the start of a read until ack has fallen again
	logic busy;

	////////////////////////////////////////
	// Handshake phases
	////////////////////////////////////////
	// busy and req high means waiting for ack,
	// busy with req low means waiting for ack to drop
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy    <= 1'b0;
			rd_req  <= 1'b0;
			rd_done <= 1'b0;
		end else begin
			rd_done <= 1'b0;
			if (!busy) begin
				if (rd_start) begin
					busy   <= 1'b1;
					rd_req <= 1'b1;
				end
			end else if (rd_req) begin
				if (rd_ack)
					rd_req <= 1'b0;
			end else if (!rd_ack) begin
				busy    <= 1'b0;
				rd_done <= 1'b1;
			end
		end
	end

	// Command held stable for the whole handshake
	always_ff @(posedge clock) begin
		if (rd_start && !busy) begin
			rd_addr <= rd_addr_next;
			rd_kind <= rd_kind_next;
		end
	end

	// Data is only valid while ack is high
	always_ff @(posedge clock) begin
		if (busy && rd_req && rd_ack)
			rd_word <= rd_data;
	end

endmodule

`default_nettype wire

// ==== logic/vertex_control_fsm.sv ====
/*
 * Vertex control FSM
 * Walks one vertex at a time through edge reads, rank reads and write-back
 */
`timescale 1ns/1ps
`default_nettype none

module vertex_control_fsm (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                fifo_valid,
	input  logic [pagerank_pkg::EDGE_W-1:0]     head_edge_base,
	output logic                                fsm_pop,
	output logic                                vertex_load,
	output logic                                edge_step,
	output logic                                vertex_done,
	output logic                                rd_start,
	output logic                                acc_clear,
	output logic                                acc_add,
	output logic                                write_start,
	output logic [pagerank_pkg::ADDR_W-1:0]     rd_addr_next,
	output pagerank_pkg::read_kind_t            rd_kind_next,
	input  logic                                rd_done,
	input  logic                                last_edge,
	input  logic                                write_done,
	input  pagerank_pkg::read_word_t            rd_word,
	input  logic [pagerank_pkg::DEGREE_W-1:0]   edge_index,
	output pagerank_pkg::vertex_state_t         state
);

	pagerank_pkg::vertex_state_t state_next;
	logic [pagerank_pkg::EDGE_W-1:0] edge_base_q;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			state <= pagerank_pkg::IDLE;
		else
			state <= state_next;
	end

	// Edge base of the job in flight
	always_ff @(posedge clock) begin
		if (fsm_pop)
			edge_base_q <= head_edge_base;
	end

	////////////////////////////////////////
	// Read address and kind
	////////////////////////////////////////
	// Rank reads use the neighbour id held in the read port
	always_comb begin
		if (state == pagerank_pkg::EDGE_READ) begin
			rd_kind_next = pagerank_pkg::READ_RANK;
			rd_addr_next = {{(pagerank_pkg::ADDR_W-pagerank_pkg::VERTEX_W){1'b0}},
				rd_word.neighbour.id};
		end else begin
			rd_kind_next = pagerank_pkg::READ_EDGE;
			rd_addr_next = edge_base_q +
				{{(pagerank_pkg::ADDR_W-pagerank_pkg::DEGREE_W){1'b0}}, edge_index};
		end
	end

	////////////////////////////////////////
	// Next state and pulses
	////////////////////////////////////////
	always_comb begin
		state_next  = state;
		fsm_pop     = 1'b0;
		vertex_load = 1'b0;
		acc_clear   = 1'b0;
		rd_start    = 1'b0;
		acc_add     = 1'b0;
		edge_step   = 1'b0;
		write_start = 1'b0;
		vertex_done = 1'b0;
		case (state)
			pagerank_pkg::IDLE: begin
				if (fifo_valid) begin
					fsm_pop     = 1'b1;
					vertex_load = 1'b1;
					acc_clear   = 1'b1;
					state_next  = pagerank_pkg::LOAD;
				end
			end
			// Counter has settled in both states, decide on another edge
			pagerank_pkg::LOAD, pagerank_pkg::ADD: begin
				if (last_edge) begin
					write_start = 1'b1;
					state_next  = pagerank_pkg::WRITE;
				end else begin
					rd_start   = 1'b1;
					state_next = pagerank_pkg::EDGE_READ;
				end
			end
			pagerank_pkg::EDGE_READ: begin
				if (rd_done) begin
					rd_start   = 1'b1;
					state_next = pagerank_pkg::RANK_READ;
				end
			end
			pagerank_pkg::RANK_READ: begin
				if (rd_done) begin
					acc_add    = 1'b1;
					edge_step  = 1'b1;
					state_next = pagerank_pkg::ADD;
				end
			end
			pagerank_pkg::WRITE: begin
				if (write_done)
					state_next = pagerank_pkg::DONE;
			end
			pagerank_pkg::DONE: begin
				vertex_done = 1'b1;
				state_next  = pagerank_pkg::IDLE;
			end
			default: state_next = pagerank_pkg::IDLE;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/edge_counter.sv ====
/*
 * Edge counter
 * Tracks the edge index of the current vertex and the running totals
 */
`timescale 1ns/1ps
`default_nettype none

module edge_counter (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                vertex_load,
	input  logic                                edge_step,
	input  logic                                vertex_done,
	input  logic [pagerank_pkg::DEGREE_W-1:0]   degree,
	output logic                                last_edge,
	output logic [pagerank_pkg::DEGREE_W-1:0]   edge_index,
	output logic [pagerank_pkg::VERTEX_W-1:0]   vertex_num_counter,
	output logic [pagerank_pkg::EDGE_W-1:0]     edge_num_counter
);

	logic [pagerank_pkg::DEGREE_W-1:0] degree_q;

	////////////////////////////////////////
	// Per-vertex edge index
	////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			degree_q   <= '0;
			edge_index <= '0;
		end else if (vertex_load) begin
			degree_q   <= degree;
			edge_index <= '0;
		end else if (edge_step) begin
			edge_index <= edge_index + 1'b1;
		end
	end

	// Degree zero is last right after the load
	assign last_edge = (edge_index == degree_q);

	////////////////////////////////////////
	// Running totals
	////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_num_counter <= '0;
			edge_num_counter   <= '0;
		end else begin
			if (vertex_done)
				vertex_num_counter <= vertex_num_counter + 1'b1;
			if (edge_step)
				edge_num_counter <= edge_num_counter + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/vertex_job_fifo.sv ====
/*
 * Vertex job FIFO
 * Takes jobs over a four-phase req/ack link and buffers them for the FSM
 */
`timescale 1ns/1ps
`default_nettype none

module vertex_job_fifo (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  logic                                 job_req,
	input  logic [pagerank_pkg::VERTEX_W-1:0]    job_vertex,
	input  logic [pagerank_pkg::EDGE_W-1:0]      job_edge_base,
	input  logic [pagerank_pkg::DEGREE_W-1:0]    job_degree,
	output logic                                 job_ack,
	input  logic                                 fsm_pop,
	output logic                                 fifo_valid,
	output logic [pagerank_pkg::VERTEX_W-1:0]    head_vertex,
	output logic [pagerank_pkg::EDGE_W-1:0]      head_edge_base,
	output logic [pagerank_pkg::DEGREE_W-1:0]    head_degree
);

	logic [pagerank_pkg::VERTEX_W-1:0] mem_vertex    [pagerank_pkg::JOB_FIFO_DEPTH];
	logic [pagerank_pkg::EDGE_W-1:0]   mem_edge_base [pagerank_pkg::JOB_FIFO_DEPTH];
	logic [pagerank_pkg::DEGREE_W-1:0] mem_degree    [pagerank_pkg::JOB_FIFO_DEPTH];
	logic [pagerank_pkg::JOB_PTR_W-1:0] wr_ptr;
	logic [pagerank_pkg::JOB_PTR_W-1:0] rd_ptr;
	logic [pagerank_pkg::JOB_CNT_W-1:0] count;
	logic full;
	logic push;

	assign full = (count == pagerank_pkg::JOB_FIFO_FULL);

	// Store on the rise of ack, only once per handshake
	assign push = job_req && !job_ack && !full;

	////////////////////////////////////////
	// Input handshake
	////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_ack <= 1'b0;
		end else if (push) begin
			job_ack <= 1'b1;
		end else if (job_ack && !job_req) begin
			job_ack <= 1'b0;
		end
	end

	// Entry storage
	always_ff @(posedge clock) begin
		if (push) begin
			mem_vertex[wr_ptr]    <= job_vertex;
			mem_edge_base[wr_ptr] <= job_edge_base;
			mem_degree[wr_ptr]    <= job_degree;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (fsm_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !fsm_pop)
				count <= count + 1'b1;
			else if (fsm_pop && !push)
				count <= count - 1'b1;
		end
	end

	assign fifo_valid     = (count != '0);
	assign head_vertex    = mem_vertex[rd_ptr];
	assign head_edge_base = mem_edge_base[rd_ptr];
	assign head_degree    = mem_degree[rd_ptr];

endmodule

`default_nettype wire

// ==== logic/pagerank_pkg.sv ====
/*
 * PageRank vertex compute unit shared definitions
 * Widths, FIFO sizing, read kinds, controller states and the read word
 */
`default_nettype none

package pagerank_pkg;

	////////////////////////////////////////
	// Field widths
	////////////////////////////////////////
	localparam int VERTEX_W = 16;
	localparam int EDGE_W   = 20;
	localparam int DEGREE_W = 8;
	localparam int RANK_W   = 32;
	localparam int ADDR_W   = 20;

	////////////////////////////////////////
	// Vertex job FIFO sizing
	////////////////////////////////////////
	// Depth must stay a power of two, pointers wrap naturally
	localparam int JOB_FIFO_DEPTH = 16;
	localparam int JOB_PTR_W      = $clog2(JOB_FIFO_DEPTH);
	localparam int JOB_CNT_W      = $clog2(JOB_FIFO_DEPTH + 1);
	localparam logic [JOB_CNT_W-1:0] JOB_FIFO_FULL = JOB_CNT_W'(JOB_FIFO_DEPTH);

	// Target array of a read
	typedef enum logic {
		READ_EDGE = 1'b0,
		READ_RANK = 1'b1
	} read_kind_t;

	// Returned word, neighbour id for edge reads, rank for rank reads
	typedef union packed {
		struct packed {
			logic [RANK_W-VERTEX_W-1:0] pad;
			logic [VERTEX_W-1:0]        id;
		} neighbour;
		logic [RANK_W-1:0] rank;
	} read_word_t;

	// Controller states
	typedef enum logic [2:0] {
		IDLE      = 3'd0,
		LOAD      = 3'd1,
		EDGE_READ = 3'd2,
		RANK_READ = 3'd3,
		ADD       = 3'd4,
		WRITE     = 3'd5,
		DONE      = 3'd6
	} vertex_state_t;

endpackage

`default_nettype wire
